/* Bender.yml */
package:
  name: kl_ebus

sources:
  - include_dirs:
      - design
    files:
      - design/kl_ebus_pkg.sv
      - design/ebus_if.sv
      - design/fe_diag_port.sv
      - design/diag_reg_board.sv
      - design/edp_slice.sv
      - design/ebus_mux.sv
      - design/kl_ebus_top.sv

  - target: test
    files:
      - verif/kl_ebus_tb.sv

/* design/diag_reg_board.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kl_ebus_cfg.svh"

// Whole-word board with a small bank of diagnostic registers.
// It answers to KL_BOARD_REGS consecutive ds codes starting at BASE
module diag_reg_board #(
  parameter kl_ebus_pkg::ds_t BASE = `KL_APR_BASE
) (
  input  wire                       clk,
  input  wire                       arst_n,
  ebus_if.board                     bus,
  output kl_ebus_pkg::ebus_driver_t driver
);

  localparam int IDX_W = $clog2(`KL_BOARD_REGS);
  localparam int HI_W  = `KL_DS_W - IDX_W;

  kl_ebus_pkg::ebus_word_t regs [`KL_BOARD_REGS];
  logic                    hit;
  logic [IDX_W-1:0]        idx;

  // The low ds bits pick the register, the high bits must match the base
  assign idx = bus.ds[HI_W +: IDX_W];
  assign hit = (bus.ds[0 +: HI_W] == BASE[0 +: HI_W]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `KL_BOARD_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (bus.diag_strobe && bus.diag_write && hit) begin
      regs[idx] <= bus.data;
    end
  end

  // Read path: drive the addressed register for the whole strobe cycle
  always_comb begin
    driver.driving = bus.diag_strobe && !bus.diag_write && hit;
    driver.data    = regs[idx];
  end

endmodule

`default_nettype wire

/* design/ebus_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Diagnostic side of the EBUS between the front end, the boards and the data mux
interface ebus_if;

  // Merged data lines, owned by the mux
  kl_ebus_pkg::ebus_word_t data;

  // Function select and strobe, owned by the front end
  kl_ebus_pkg::ds_t ds;
  logic diag_strobe;
  logic diag_write;

  modport fe (
    output ds,
    output diag_strobe,
    output diag_write,
    input  data
  );

  modport board (
    input data,
    input ds,
    input diag_strobe,
    input diag_write
  );

  modport mux (
    output data
  );

endinterface

`default_nettype wire

/* design/ebus_mux.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kl_ebus_cfg.svh"

// Priority mux for the EBUS data lines. The first driving source wins,
// with the EDP slices treated as one group that builds a word field by field
module ebus_mux (
  input  kl_ebus_pkg::ebus_driver_t fe_driver,
  input  kl_ebus_pkg::ebus_driver_t apr_driver,
  input  kl_ebus_pkg::ebus_driver_t con_driver,
  input  kl_ebus_pkg::ebus_driver_t edp_drivers [`KL_NUM_SLICES],
  ebus_if.mux                       bus
);

  logic                    edp_any;
  kl_ebus_pkg::ebus_word_t edp_word;

  // Any slice driving means the whole group owns the bus
  always_comb begin
    edp_any  = 1'b0;
    edp_word = '0;
    for (int s = 0; s < `KL_NUM_SLICES; s++) begin
      edp_any = edp_any | edp_drivers[s].driving;
      edp_word[s*`KL_SLICE_W +: `KL_SLICE_W] =
        edp_drivers[s].data[s*`KL_SLICE_W +: `KL_SLICE_W];
    end
  end

  always_comb begin
    if (fe_driver.driving) begin
      bus.data = fe_driver.data;
    end else if (apr_driver.driving) begin
      bus.data = apr_driver.data;
    end else if (con_driver.driving) begin
      bus.data = con_driver.data;
    end else if (edp_any) begin
      bus.data = edp_word;
    end else begin
      // Nobody answered, so an unmapped read sees zero
      bus.data = '0;
    end
  end

endmodule

`default_nettype wire

/* design/edp_slice.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kl_ebus_cfg.svh"

// One EDP slice. It keeps a 6-bit field of AR and of ARX, at word bits
// SLICE*6 through SLICE*6+5
module edp_slice #(
  parameter int SLICE = 0
) (
  input  wire                       clk,
  input  wire                       arst_n,
  ebus_if.board                     bus,
  output kl_ebus_pkg::ebus_driver_t driver
);

  localparam int LSB = SLICE * `KL_SLICE_W;

  logic [0:`KL_SLICE_W-1] ar_q;
  logic [0:`KL_SLICE_W-1] arx_q;
  logic                   hit_ar;
  logic                   hit_arx;

  assign hit_ar  = (bus.ds == `KL_EDP_AR_DS);
  assign hit_arx = (bus.ds == `KL_EDP_ARX_DS);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ar_q  <= '0;
      arx_q <= '0;
    end else if (bus.diag_strobe && bus.diag_write) begin
      if (hit_ar) begin
        ar_q <= bus.data[LSB +: `KL_SLICE_W];
      end
      if (hit_arx) begin
        arx_q <= bus.data[LSB +: `KL_SLICE_W];
      end
    end
  end

  // Only our own field is filled, the mux stitches the six slices together
  always_comb begin
    driver.driving = bus.diag_strobe && !bus.diag_write && (hit_ar || hit_arx);
    driver.data    = '0;
    driver.data[LSB +: `KL_SLICE_W] = hit_arx ? arx_q : ar_q;
  end

endmodule

`default_nettype wire

/* design/fe_diag_port.sv */
`timescale 1ns/100ps
`default_nettype none

// Front-end diagnostic port. One request at a time goes through a single
// strobe cycle on the EBUS and comes back as a response word
module fe_diag_port (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     req_valid,
  output logic                    req_ready,
  input  wire                     req_write,
  input  kl_ebus_pkg::ds_t        req_ds,
  input  kl_ebus_pkg::ebus_word_t req_data,
  output logic                    rsp_valid,
  input  wire                     rsp_ready,
  output kl_ebus_pkg::ebus_word_t rsp_data,
  ebus_if.fe                      bus,
  output kl_ebus_pkg::ebus_driver_t fe_driver
);

  typedef enum logic [1:0] {
    IDLE,
    STROBE,
    RESPOND
  } state_t;

  state_t                  state;
  kl_ebus_pkg::ds_t        ds_q;
  logic                    write_q;
  kl_ebus_pkg::ebus_word_t wdata_q;
  kl_ebus_pkg::ebus_word_t rsp_data_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      ds_q       <= '0;
      write_q    <= 1'b0;
      wdata_q    <= '0;
      rsp_data_q <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (req_valid) begin
            state   <= STROBE;
            ds_q    <= req_ds;
            write_q <= req_write;
            wdata_q <= req_data;
          end
        end
        // The strobe always lasts exactly one cycle. For a write the bus
        // carries our own word, so the echo comes for free
        STROBE: begin
          state      <= RESPOND;
          rsp_data_q <= bus.data;
        end
        RESPOND: begin
          if (rsp_ready) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign bus.ds          = ds_q;
  assign bus.diag_strobe = (state == STROBE);
  assign bus.diag_write  = write_q;

  // The front end outranks every board on the data mux during a write strobe
  always_comb begin
    fe_driver.driving = (state == STROBE) && write_q;
    fe_driver.data    = wdata_q;
  end

  assign req_ready = (state == IDLE);
  assign rsp_valid = (state == RESPOND);
  assign rsp_data  = rsp_data_q;

endmodule

`default_nettype wire

/* design/kl_ebus_cfg.svh */
`ifndef KL_EBUS_CFG_SVH
`define KL_EBUS_CFG_SVH

// One EBUS word, numbered 0 to 35 with bit 0 the most significant
`define KL_WORD_W 36

// Diagnostic select code carried on the DS lines
`define KL_DS_W 7

// Each EDP slice owns one 6-bit field of the 36-bit word
`define KL_SLICE_W 6
`define KL_NUM_SLICES 6

// Base codes of the two whole-word boards, aligned to KL_BOARD_REGS
`define KL_APR_BASE 7'h00
`define KL_CON_BASE 7'h10

// The EDP slices answer to these two codes together
`define KL_EDP_AR_DS 7'h20
`define KL_EDP_ARX_DS 7'h21

// Diagnostic registers held on each whole-word board
`define KL_BOARD_REGS 8

`endif

/* design/kl_ebus_pkg.sv */
`default_nettype none

`include "kl_ebus_cfg.svh"

package kl_ebus_pkg;

  // EBUS data word in KL10 bit order, bit 0 is the MSB
  typedef logic [0:`KL_WORD_W-1] ebus_word_t;

  // Diagnostic select code, ds[0] is the MSB as on the backplane
  typedef logic [0:`KL_DS_W-1] ds_t;

  // What one board offers to the EBUS data mux.
  // The mux only looks at data when driving is set
  typedef struct packed {
    logic       driving;
    ebus_word_t data;
  } ebus_driver_t;

endpackage

`default_nettype wire

/* design/kl_ebus_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "kl_ebus_cfg.svh"

// Diagnostic EBUS backplane: front-end port, two whole-word boards,
// the six EDP slices and the data mux
module kl_ebus_top (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire                     req_valid,
  output logic                    req_ready,
  input  wire                     req_write,
  input  kl_ebus_pkg::ds_t        req_ds,
  input  kl_ebus_pkg::ebus_word_t req_data,
  output logic                    rsp_valid,
  input  wire                     rsp_ready,
  output kl_ebus_pkg::ebus_word_t rsp_data
);

  kl_ebus_pkg::ebus_driver_t fe_driver;
  kl_ebus_pkg::ebus_driver_t apr_driver;
  kl_ebus_pkg::ebus_driver_t con_driver;
  kl_ebus_pkg::ebus_driver_t edp_drivers [`KL_NUM_SLICES];

  ebus_if ebus ();

  fe_diag_port i_fe (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_ds    (req_ds),
    .req_data  (req_data),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data),
    .bus       (ebus.fe),
    .fe_driver (fe_driver)
  );

  diag_reg_board #(
    .BASE (`KL_APR_BASE)
  ) i_apr (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (ebus.board),
    .driver (apr_driver)
  );

  diag_reg_board #(
    .BASE (`KL_CON_BASE)
  ) i_con (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (ebus.board),
    .driver (con_driver)
  );

  // Slice 0 holds word bits 0 to 5, slice 5 holds bits 30 to 35
  for (genvar s = 0; s < `KL_NUM_SLICES; s++) begin : g_edp
    edp_slice #(
      .SLICE (s)
    ) i_slice (
      .clk    (clk),
      .arst_n (arst_n),
      .bus    (ebus.board),
      .driver (edp_drivers[s])
    );
  end

  ebus_mux i_mux (
    .fe_driver   (fe_driver),
    .apr_driver  (apr_driver),
    .con_driver  (con_driver),
    .edp_drivers (edp_drivers),
    .bus         (ebus.mux)
  );

endmodule

`default_nettype wire

/* project.f */
+incdir+design
design/kl_ebus_pkg.sv
design/ebus_if.sv
design/fe_diag_port.sv
design/diag_reg_board.sv
design/edp_slice.sv
design/ebus_mux.sv
design/kl_ebus_top.sv
verif/kl_ebus_tb.sv

/* verif/kl_ebus_tb.sv */
`timescale 1ns/100ps
`default_nettype none

// Table-driven testbench for the diagnostic EBUS. Each table entry becomes one
// request, and rsp_ready is stalled in random stretches to exercise back-pressure
module kl_ebus_tb;

  localparam int CLK_HALF      = 4;
  localparam int RESET_CYCLES  = 10;
  localparam int CYCLES_PER_OP = 40;
  localparam int RSP_LATENCY   = 2;

  typedef struct packed {
    logic                    write;
    kl_ebus_pkg::ds_t        ds;
    kl_ebus_pkg::ebus_word_t data;
    kl_ebus_pkg::ebus_word_t exp;
  } entry_t;

  logic                    clk;
  logic                    arst_n;
  logic                    req_valid;
  logic                    req_ready;
  logic                    req_write;
  kl_ebus_pkg::ds_t        req_ds;
  kl_ebus_pkg::ebus_word_t req_data;
  logic                    rsp_valid;
  logic                    rsp_ready;
  kl_ebus_pkg::ebus_word_t rsp_data;

  entry_t entries [$];
  integer seed = 32'h499c;
  int     stall_left = 0;
  int     cycles = 0;
  int     cycle_limit = 0;
  int     err_word = 0;
  int     err_latency = 0;
  int     err_flag = 0;

  kl_ebus_top i_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_ds    (req_ds),
    .req_data  (req_data),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_data  (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #CLK_HALF clk = ~clk;
    end
  end

  // The consumer keeps ready high and now and then drops it for 1 to 4 cycles
  always @(posedge clk) begin
    if (stall_left > 0) begin
      rsp_ready <= 1'b0;
      stall_left = stall_left - 1;
    end else begin
      rsp_ready <= 1'b1;
      if (($random(seed) & 1) == 0) begin
        stall_left = ($random(seed) & 3) + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT never finished the request sequence",
               cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input kl_ebus_pkg::ebus_word_t exp,
                            input kl_ebus_pkg::ebus_word_t act);
    if (act !== exp) begin
      err_word++;
      $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_flag++;
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // Called right after the acceptance edge. It counts falling edges until rsp_valid
  task automatic check_latency();
    int lat;
    @(negedge clk);
    lat = 1;
    while (!rsp_valid) begin
      @(negedge clk);
      lat++;
    end
    if (lat != RSP_LATENCY) begin
      err_latency++;
      $display("ERR t=%0t rsp_latency expected %0d actual %0d", $time, RSP_LATENCY, lat);
    end
  endtask

  task automatic add_entry(input logic write, input kl_ebus_pkg::ds_t ds,
                           input kl_ebus_pkg::ebus_word_t data,
                           input kl_ebus_pkg::ebus_word_t exp);
    entry_t e;
    e.write = write;
    e.ds    = ds;
    e.data  = data;
    e.exp   = exp;
    entries.push_back(e);
  endtask

  task automatic build_table();
    // Everything reads as zero straight out of reset
    add_entry(1'b0, 7'h00, 36'h0, 36'h0);
    add_entry(1'b0, 7'h07, 36'h0, 36'h0);
    add_entry(1'b0, 7'h10, 36'h0, 36'h0);
    add_entry(1'b0, 7'h17, 36'h0, 36'h0);
    add_entry(1'b0, 7'h20, 36'h0, 36'h0);
    add_entry(1'b0, 7'h21, 36'h0, 36'h0);
    // APR board, then its neighbours and the same offset on CON
    add_entry(1'b1, 7'h03, 36'h123456789, 36'h123456789);
    add_entry(1'b0, 7'h03, 36'h0, 36'h123456789);
    add_entry(1'b0, 7'h02, 36'h0, 36'h0);
    add_entry(1'b0, 7'h04, 36'h0, 36'h0);
    add_entry(1'b0, 7'h13, 36'h0, 36'h0);
    // CON board
    add_entry(1'b1, 7'h15, 36'hFEDCBA987, 36'hFEDCBA987);
    add_entry(1'b0, 7'h15, 36'h0, 36'hFEDCBA987);
    add_entry(1'b0, 7'h14, 36'h0, 36'h0);
    add_entry(1'b0, 7'h16, 36'h0, 36'h0);
    add_entry(1'b0, 7'h05, 36'h0, 36'h0);
    // AR and ARX are built from six 6-bit slices
    add_entry(1'b1, 7'h20, 36'hA5C396E1F, 36'hA5C396E1F);
    add_entry(1'b0, 7'h20, 36'h0, 36'hA5C396E1F);
    add_entry(1'b1, 7'h21, 36'h0F0F0F0F0, 36'h0F0F0F0F0);
    add_entry(1'b0, 7'h21, 36'h0, 36'h0F0F0F0F0);
    add_entry(1'b0, 7'h20, 36'h0, 36'hA5C396E1F);
    // Nobody answers these codes
    add_entry(1'b0, 7'h08, 36'h0, 36'h0);
    add_entry(1'b0, 7'h7F, 36'h0, 36'h0);
    add_entry(1'b0, 7'h22, 36'h0, 36'h0);
    add_entry(1'b0, 7'h18, 36'h0, 36'h0);
    // A write to nowhere still echoes the front-end word
    add_entry(1'b1, 7'h30, 36'h5A5A5A5A5, 36'h5A5A5A5A5);
    add_entry(1'b0, 7'h30, 36'h0, 36'h0);
  endtask

  task automatic run_request(input entry_t e);
    kl_ebus_pkg::ebus_word_t first;
    @(posedge clk);
    req_valid <= 1'b1;
    req_write <= e.write;
    req_ds    <= e.ds;
    req_data  <= e.data;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    // The port takes the request on this edge
    @(posedge clk);
    req_valid <= 1'b0;
    check_latency();
    first = rsp_data;
    check_word("rsp_data", e.exp, rsp_data);
    check_flag("req_ready", 1'b0, req_ready);
    while (!rsp_ready) begin
      @(negedge clk);
      check_flag("rsp_valid", 1'b1, rsp_valid);
      check_flag("req_ready", 1'b0, req_ready);
      check_word("rsp_data", first, rsp_data);
    end
    @(posedge clk);
    @(negedge clk);
    check_flag("req_ready", 1'b1, req_ready);
    check_flag("rsp_valid", 1'b0, rsp_valid);
  endtask

  initial begin
    arst_n    = 1'b0;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_ds    = '0;
    req_data  = '0;
    rsp_ready = 1'b0;
    build_table();
    cycle_limit = entries.size() * CYCLES_PER_OP + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_flag("req_ready", 1'b1, req_ready);
    check_flag("rsp_valid", 1'b0, rsp_valid);
    check_flag("diag_strobe", 1'b0, i_dut.ebus.diag_strobe);
    check_word("rsp_data", '0, rsp_data);
    foreach (entries[i]) begin
      run_request(entries[i]);
    end
    $display("Errors: word %0d, latency %0d, flag %0d", err_word, err_latency, err_flag);
    if (err_word + err_latency + err_flag == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
